// ==== verilog/mem_pkg.sv ====
package mem_pkg;

  // one memory line holds a whole burst of output words.
  localparam int line_width = 512;

  // lines are addressed, not bytes.
  localparam int addr_width = 16;

  typedef logic [line_width-1:0] line_t;

  typedef logic [addr_width-1:0] line_addr_t;

  // the request bit is a one-cycle strobe.
  // addr stays put until the next request.
  typedef struct packed {
    logic       request;
    line_addr_t addr;
  } read_req_t;

endpackage

// ==== verilog/stream_pkg.sv ====
package stream_pkg;

  import mem_pkg::*;

  localparam int word_width = 16;

  // words are taken from a line lowest word first.
  localparam int words_per_line = line_width / word_width;

  localparam int count_width = 16;

  // bits that pick a word inside a line.
  localparam int word_index_width = $clog2(words_per_line);

  // enough bits for a full count rounded up to whole lines.
  localparam int line_count_width = count_width + 1 - word_index_width;

  typedef logic [word_width-1:0] word_t;

  typedef struct packed {
    logic [mem_pkg::addr_width-1:0] base;
    logic [count_width-1:0]         count;
  } job_t;

endpackage

// ==== verilog/line_fetcher.sv ====
`timescale 1ns/1ps

module line_fetcher (
  input  logic                clk,
  input  logic                rst,
  input  logic                job_start,
  input  stream_pkg::job_t    job,
  input  logic                job_done,
  input  logic                available_read,
  output mem_pkg::read_req_t  rd_req,
  input  logic                data_valid,
  input  mem_pkg::line_t      read_data,
  input  logic                buffer_read,
  output logic                has_buffer,
  output mem_pkg::line_t      buffer
);

  import mem_pkg::*;
  import stream_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_full
  } state_t;

  state_t                      state;
  logic [line_count_width-1:0] lines_left;
  logic [addr_width-1:0]       next_addr;
  logic [count_width:0]        padded_count;

  // round the word count up to whole lines.
  assign padded_count = {1'b0, job.count} + (count_width + 1)'(words_per_line - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= st_idle;
      lines_left     <= '0;
      rd_req.request <= 1'b0;
      has_buffer     <= 1'b0;
    end else begin
      rd_req.request <= 1'b0;
      case (state)
        st_idle: begin
          if (available_read && lines_left != '0) begin
            rd_req.request <= 1'b1;
            rd_req.addr    <= next_addr;
            next_addr      <= next_addr + 1'b1;
            lines_left     <= lines_left - 1'b1;
            state          <= st_wait;
          end
        end
        st_wait: begin
          // only one read is ever outstanding.
          if (data_valid) begin
            buffer     <= read_data;
            has_buffer <= 1'b1;
            state      <= st_full;
          end
        end
        st_full: begin
          if (buffer_read || job_done) begin
            has_buffer <= 1'b0;
            state      <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase

      if (job_done) begin
        lines_left <= '0;
      end

      // a new job can arrive in the same cycle that the old one ends.
      if (job_start) begin
        lines_left <= padded_count[count_width:word_index_width];
        next_addr  <= job.base;
      end
    end
  end

endmodule

// ==== verilog/word_unpacker.sv ====
`timescale 1ns/1ps

module word_unpacker (
  input  logic              clk,
  input  logic              rst,
  input  logic              has_buffer,
  input  mem_pkg::line_t    buffer,
  output logic              buffer_read,
  input  logic              pop_ok,
  input  logic              job_done,
  output logic              words_ready,
  output stream_pkg::word_t data_out
);

  import mem_pkg::*;
  import stream_pkg::*;

  line_t                     data;
  logic [words_per_line-1:0] position;
  logic                      last_word;
  logic                      buffer_fresh;

  assign data_out  = data[word_width-1:0];
  assign last_word = position[words_per_line-1];

  // the fetcher drops has_buffer one cycle after buffer_read.
  assign buffer_fresh = has_buffer & ~buffer_read;

  always_ff @(posedge clk) begin
    if (rst) begin
      words_ready <= 1'b0;
      position    <= '0;
      buffer_read <= 1'b0;
    end else begin
      buffer_read <= 1'b0;
      if (!words_ready) begin
        if (buffer_fresh) begin
          data        <= buffer;
          position    <= words_per_line'(1);
          buffer_read <= 1'b1;
          words_ready <= 1'b1;
        end
      end else if (pop_ok) begin
        if (!last_word) begin
          data     <= data >> word_width;
          position <= position << 1;
        end else if (buffer_fresh) begin
          // go straight on to the next line without a gap.
          data        <= buffer;
          position    <= words_per_line'(1);
          buffer_read <= 1'b1;
        end else begin
          data        <= data >> word_width;
          position    <= '0;
          words_ready <= 1'b0;
        end
      end

      // the unused tail of the last line is thrown away here.
      if (job_done) begin
        data        <= '0;
        position    <= '0;
        words_ready <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/stream_limiter.sv ====
`timescale 1ns/1ps

module stream_limiter (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  stream_pkg::job_t job,
  output logic             job_start,
  input  logic             words_ready,
  input  logic             pop,
  output logic             pop_ok,
  output logic             available_pop,
  output logic             busy,
  output logic             done,
  output logic             job_done
);

  import stream_pkg::*;

  logic [count_width-1:0] remaining;
  logic                   last_pop;

  // starts while busy and empty jobs are ignored.
  assign job_start = start & ~busy & (job.count != '0);

  assign available_pop = words_ready & (remaining != '0);
  assign pop_ok        = pop & available_pop;
  assign last_pop      = pop_ok & (remaining == count_width'(1));

  // the fetcher and unpacker see the same end of job as the outside.
  assign job_done = done;

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (job_start) begin
        remaining <= job.count;
        busy      <= 1'b1;
      end else if (pop_ok) begin
        remaining <= remaining - 1'b1;
        if (last_pop) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/line_streamer.sv ====
`timescale 1ns/1ps

module line_streamer (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  stream_pkg::job_t   job,
  output logic               busy,
  output logic               done,
  input  logic               available_read,
  output mem_pkg::read_req_t rd_req,
  input  logic               data_valid,
  input  mem_pkg::line_t     read_data,
  output logic               available_pop,
  input  logic               pop,
  output stream_pkg::word_t  data_out
);

  import mem_pkg::*;

  logic  job_start;
  logic  job_done;
  logic  has_buffer;
  line_t buffer;
  logic  buffer_read;
  logic  words_ready;
  logic  pop_ok;

  line_fetcher u_fetcher (
    .clk            (clk),
    .rst            (rst),
    .job_start      (job_start),
    .job            (job),
    .job_done       (job_done),
    .available_read (available_read),
    .rd_req         (rd_req),
    .data_valid     (data_valid),
    .read_data      (read_data),
    .buffer_read    (buffer_read),
    .has_buffer     (has_buffer),
    .buffer         (buffer)
  );

  word_unpacker u_unpacker (
    .clk         (clk),
    .rst         (rst),
    .has_buffer  (has_buffer),
    .buffer      (buffer),
    .buffer_read (buffer_read),
    .pop_ok      (pop_ok),
    .job_done    (job_done),
    .words_ready (words_ready),
    .data_out    (data_out)
  );

  stream_limiter u_limiter (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .job           (job),
    .job_start     (job_start),
    .words_ready   (words_ready),
    .pop           (pop),
    .pop_ok        (pop_ok),
    .available_pop (available_pop),
    .busy          (busy),
    .done          (done),
    .job_done      (job_done)
  );

endmodule

// ==== testbench/tb_line_streamer.sv ====
`timescale 1ns/1ps

module tb_line_streamer;

  import mem_pkg::*;
  import stream_pkg::*;

  // jobs of 1, 32, 33 and 100 words, with generous room for consumer pauses.
  localparam int total_words     = 166;
  localparam int cycles_per_word = 20;
  localparam int timeout_cycles  = 6 * total_words * cycles_per_word;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  logic      start = 1'b0;
  job_t      job = '0;
  logic      busy;
  logic      done;
  logic      available_read = 1'b0;
  read_req_t rd_req;
  logic      data_valid = 1'b0;
  line_t     read_data = '0;
  logic      available_pop;
  logic      pop = 1'b0;
  word_t     data_out;

  integer     seed = 5;
  int         cycles = 0;
  logic       long_pauses = 1'b0;
  int         pause_left = 0;
  logic       mem_busy = 1'b0;
  int         mem_wait = 0;
  line_addr_t mem_addr = '0;

  logic  job_open;
  int    job_base;
  int    job_count;
  int    lines_needed;
  int    pop_index;
  int    req_count;
  logic  outstanding;
  word_t prev_data;
  logic  accepted;

  line_streamer dut0 (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .job            (job),
    .busy           (busy),
    .done           (done),
    .available_read (available_read),
    .rd_req         (rd_req),
    .data_valid     (data_valid),
    .read_data      (read_data),
    .available_pop  (available_pop),
    .pop            (pop),
    .data_out       (data_out)
  );

  always #5 clk = ~clk;

  // word i of line a holds the low bits of a times the words per line plus i.
  function automatic word_t line_word(input int base, input int index);
    return word_t'(base * words_per_line + index);
  endfunction

  function automatic line_t make_line(input line_addr_t addr);
    line_t line;
    for (int i = 0; i < words_per_line; i++) begin
      line[i*word_width +: word_width] = line_word(int'(addr), i);
    end
    return line;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  assign accepted = pop & available_pop;

  // the memory model and the consumer both change their outputs on the falling edge.
  always @(negedge clk) begin
    data_valid = 1'b0;
    if (rst) begin
      available_read = 1'b0;
      pop = 1'b0;
      mem_busy = 1'b0;
    end else begin
      available_read = ($random(seed) & 3) != 0;
      if (rd_req.request) begin
        mem_addr = rd_req.addr;
        mem_wait = 1 + ($random(seed) & 3);
        mem_busy = 1'b1;
      end else if (mem_busy) begin
        mem_wait = mem_wait - 1;
        if (mem_wait == 0) begin
          read_data = make_line(mem_addr);
          data_valid = 1'b1;
          mem_busy = 1'b0;
        end
      end
      if (pause_left > 0) begin
        pause_left = pause_left - 1;
        pop = 1'b0;
      end else if (long_pauses && ($random(seed) & 31) == 0) begin
        pause_left = 20 + ($random(seed) & 31);
        pop = 1'b0;
      end else begin
        pop = ($random(seed) & 1) != 0;
      end
    end
  end

  // a job opens on a start with a nonzero count while none is open, and closes on done.
  always @(posedge clk) begin
    if (rst) begin
      job_open     <= 1'b0;
      job_base     <= 0;
      job_count    <= 0;
      lines_needed <= 0;
      pop_index    <= 0;
      req_count    <= 0;
      outstanding  <= 1'b0;
    end else begin
      if (start && !job_open && job.count != '0) begin
        job_open     <= 1'b1;
        job_base     <= int'(job.base);
        job_count    <= int'(job.count);
        lines_needed <= (int'(job.count) + words_per_line - 1) / words_per_line;
        pop_index    <= 0;
        req_count    <= 0;
      end
      if (done) begin
        job_open <= 1'b0;
      end
      if (accepted) begin
        pop_index <= pop_index + 1;
      end
      if (rd_req.request) begin
        req_count   <= req_count + 1;
        outstanding <= 1'b1;
      end else if (data_valid) begin
        outstanding <= 1'b0;
      end
    end
    prev_data <= data_out;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      fail_run($sformatf("timeout after %0d cycles, a job never finished", cycles));
    end
  end

  data_value: assert property (@(posedge clk) disable iff (rst)
      accepted |-> data_out == line_word(job_base, pop_index))
    else fail_run($sformatf("CHECK FAILED at %0t: data_out is %h, expected %h", $time,
      $sampled(data_out), line_word($sampled(job_base), $sampled(pop_index))));

  pop_limit: assert property (@(posedge clk) disable iff (rst)
      accepted |-> job_open && pop_index < job_count)
    else fail_run($sformatf("CHECK FAILED at %0t: pop_count is %0d, expected below %0d",
      $time, $sampled(pop_index) + 1, $sampled(job_count)));

  done_after_last: assert property (@(posedge clk) disable iff (rst)
      accepted && pop_index == job_count - 1 |=> done)
    else fail_run($sformatf("CHECK FAILED at %0t: done is 0, expected 1", $time));

  done_in_job: assert property (@(posedge clk) disable iff (rst) done |-> job_open)
    else fail_run($sformatf("done pulsed at %0t although no job was running", $time));

  done_pops: assert property (@(posedge clk) disable iff (rst)
      done |-> pop_index == job_count)
    else fail_run($sformatf("CHECK FAILED at %0t: pop_count is %0d, expected %0d", $time,
      $sampled(pop_index), $sampled(job_count)));

  done_reads: assert property (@(posedge clk) disable iff (rst)
      done |-> req_count == lines_needed)
    else fail_run($sformatf("CHECK FAILED at %0t: read_count is %0d, expected %0d", $time,
      $sampled(req_count), $sampled(lines_needed)));

  busy_in_job: assert property (@(posedge clk) disable iff (rst)
      job_open && !done |-> busy)
    else fail_run($sformatf("CHECK FAILED at %0t: busy is 0, expected 1", $time));

  idle_quiet: assert property (@(posedge clk) disable iff (rst)
      !job_open |-> !busy && !done && !available_pop && !rd_req.request)
    else fail_run($sformatf("outputs active at %0t with no job running", $time));

  req_pulse: assert property (@(posedge clk) disable iff (rst)
      rd_req.request |=> !rd_req.request)
    else fail_run($sformatf("rd_req.request stayed high for two cycles at %0t", $time));

  req_single: assert property (@(posedge clk) disable iff (rst)
      rd_req.request |-> !outstanding)
    else fail_run($sformatf("a read was requested at %0t before the last one returned", $time));

  // a request answers an available_read seen at the edge before.
  req_available: assert property (@(posedge clk) disable iff (rst)
      rd_req.request |-> $past(available_read))
    else fail_run($sformatf("a read was requested at %0t while available_read was low", $time));

  req_addr: assert property (@(posedge clk) disable iff (rst)
      rd_req.request |-> rd_req.addr == line_addr_t'(job_base + req_count))
    else fail_run($sformatf("CHECK FAILED at %0t: rd_req.addr is %h, expected %h", $time,
      $sampled(rd_req.addr), line_addr_t'($sampled(job_base) + $sampled(req_count))));

  req_limit: assert property (@(posedge clk) disable iff (rst)
      rd_req.request |-> req_count < lines_needed)
    else fail_run($sformatf("more reads than lines in the job at %0t", $time));

  hold_word: assert property (@(posedge clk) disable iff (rst)
      available_pop && !pop |=> data_out == prev_data)
    else fail_run($sformatf("CHECK FAILED at %0t: data_out is %h, expected %h", $time,
      $sampled(data_out), $sampled(prev_data)));

  task automatic pulse_start(input logic [15:0] base, input logic [15:0] count);
    job.base  = base;
    job.count = count;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic run_job(input logic [15:0] base, input logic [15:0] count,
                         input logic stray_start);
    pulse_start(base, count);
    if (stray_start) begin
      repeat (5) @(negedge clk);
      pulse_start(base ^ 16'h1111, 16'd7);
    end
    while (!done) @(negedge clk);
    repeat (8) @(negedge clk);
  endtask

  initial begin
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (10) @(negedge clk);
    pulse_start(16'h0040, 16'd0);
    repeat (20) @(negedge clk);
    run_job(16'h0010, 16'd1, 1'b0);
    run_job(16'h0100, 16'd32, 1'b0);
    // the last word of this job wraps around to zero.
    run_job(16'h07ff, 16'd33, 1'b0);
    long_pauses = 1'b1;
    run_job(16'h2345, 16'd100, 1'b1);
    long_pauses = 1'b0;
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/mem_pkg.sv
verilog/stream_pkg.sv
verilog/line_fetcher.sv
verilog/word_unpacker.sv
verilog/stream_limiter.sv
verilog/line_streamer.sv
testbench/tb_line_streamer.sv

// ==== run.sh ====
#!/bin/sh
# Build the line streamer testbench with Verilator, run it and look for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_line_streamer \
  -f compile.f -o tb_line_streamer \
  && ./obj_dir/tb_line_streamer | tee /dev/stderr | grep -q "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
